/* rtl/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] register_t;
	typedef logic [3:0] tag_t;

	// multiplier pipeline depth and divider iteration count
	localparam int MUL_LATENCY = 2;
	localparam int DIV_STEPS = 32;

	// codes 28 to 31 are left undefined and fault in execute
	typedef enum logic [4:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_SLT, OP_SLTU,
		OP_JAL,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
		OP_LOAD, OP_STORE,
		OP_MUL, OP_MULH, OP_MULHU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_CSRRW, OP_CSRRS,
		OP_ECALL, OP_MRET
	} exec_op_t;

	typedef enum logic [2:0] {
		SEL_ZERO,
		SEL_RS1,
		SEL_RS2,
		SEL_PC,
		SEL_IMM
	} operand_sel_t;

	typedef enum logic [1:0] {
		WIDTH_BYTE,
		WIDTH_HALF,
		WIDTH_WORD
	} mem_width_t;

	// ==================================================
	// stage records

	typedef struct packed {
		tag_t tag;
		word_t pc;
		word_t imm;
		exec_op_t op;
		operand_sel_t operand1;
		operand_sel_t operand2;
		register_t inst_rd;
		mem_width_t mem_width;
		logic mem_signed;
	} decode_data_t;

	typedef struct packed {
		tag_t tag;
		word_t rd;
		register_t inst_rd;
		logic mem_read;
		logic mem_write;
		mem_width_t mem_width;
		logic mem_signed;
		word_t mem_address;
		// load destination handed on to the memory stage
		register_t mem_inst_rd;
	} execute_data_t;

endpackage

`default_nettype wire

/* rtl/cpu_csr_pkg.sv */
`default_nettype none

package cpu_csr_pkg;

	// machine CSR addresses
	typedef enum logic [11:0] {
		CSR_MSCRATCH = 12'h340,
		CSR_MTVEC = 12'h305,
		CSR_MEPC = 12'h341,
		CSR_MCAUSE = 12'h342
	} csr_index_t;

	// environment call from machine mode
	localparam logic [31:0] CAUSE_ECALL = 32'd11;

	// trap vector after reset
	localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;

endpackage

`default_nettype wire

/* rtl/cpu_csr_if.sv */
`default_nettype none

interface cpu_csr_if;
	import cpu_types_pkg::*;

	// read side is combinational from index
	logic [11:0] index;
	word_t rdata;

	// write and trap pulses take effect on the following edge
	logic wdata_wr;
	word_t wdata;
	logic ecall;
	word_t ecall_pc;

	// trap return and trap vector
	word_t epc;
	word_t tvec;

	modport execute (
		output index, wdata_wr, wdata, ecall, ecall_pc,
		input rdata, epc, tvec
	);

	modport csr (
		input index, wdata_wr, wdata, ecall, ecall_pc,
		output rdata, epc, tvec
	);

endinterface

`default_nettype wire

/* rtl/cpu_alu.sv */
`default_nettype none

module cpu_alu (
	input cpu_types_pkg::exec_op_t i_op,
	input cpu_types_pkg::word_t i_op1,
	input cpu_types_pkg::word_t i_op2,
	output cpu_types_pkg::word_t o_result,
	output cpu_types_pkg::word_t o_shift_result,
	output cpu_types_pkg::word_t o_signed_sum_result,
	output logic o_compare_result
);
	import cpu_types_pkg::*;

	logic [4:0] shift_amount;

	assign shift_amount = i_op2[4:0];

	// address adder also used for jump targets
	assign o_signed_sum_result = i_op1 + i_op2;

	always_comb begin
		case (i_op)
			OP_SUB: o_result = i_op1 - i_op2;
			OP_AND: o_result = i_op1 & i_op2;
			OP_OR: o_result = i_op1 | i_op2;
			OP_XOR: o_result = i_op1 ^ i_op2;
			default: o_result = i_op1 + i_op2;
		endcase
	end

	always_comb begin
		case (i_op)
			OP_SLL: o_shift_result = i_op1 << shift_amount;
			OP_SRL: o_shift_result = i_op1 >> shift_amount;
			OP_SRA: o_shift_result = word_t'($signed(i_op1) >>> shift_amount);
			default: o_shift_result = i_op1;
		endcase
	end

	// set-less-than and branch conditions
	always_comb begin
		case (i_op)
			OP_SLT,
			OP_BLT: o_compare_result = $signed(i_op1) < $signed(i_op2);
			OP_SLTU: o_compare_result = i_op1 < i_op2;
			OP_BEQ: o_compare_result = i_op1 == i_op2;
			OP_BNE: o_compare_result = i_op1 != i_op2;
			OP_BGE: o_compare_result = $signed(i_op1) >= $signed(i_op2);
			default: o_compare_result = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/cpu_multiply.sv */
`default_nettype none

module cpu_multiply (
	input logic i_clock,
	input logic i_latch,
	input logic i_op1_signed,
	input logic i_op2_signed,
	input cpu_types_pkg::word_t i_op1,
	input cpu_types_pkg::word_t i_op2,
	output logic [63:0] o_result
);

	// 33 bits so one signed multiplier covers both signed and unsigned
	logic signed [32:0] op1_q;
	logic signed [32:0] op2_q;
	logic signed [65:0] product_q;

	// first stage holds the operands after the first cycle
	always_ff @(posedge i_clock) begin
		if (i_latch) begin
			op1_q <= {i_op1_signed & i_op1[31], i_op1};
			op2_q <= {i_op2_signed & i_op2[31], i_op2};
		end
	end

	// second stage
	always_ff @(posedge i_clock) begin
		product_q <= op1_q * op2_q;
	end

	assign o_result = product_q[63:0];

endmodule

`default_nettype wire

/* rtl/cpu_divide.sv */
`default_nettype none

module cpu_divide (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input logic i_signed,
	input cpu_types_pkg::word_t i_numerator,
	input cpu_types_pkg::word_t i_denominator,
	output cpu_types_pkg::word_t o_quotient,
	output cpu_types_pkg::word_t o_remainder,
	output logic o_done
);
	import cpu_types_pkg::*;

	typedef logic [$clog2(DIV_STEPS + 1) - 1:0] count_t;

	count_t count;
	logic running;
	word_t numerator_abs;
	word_t denominator_abs;
	word_t quotient_q;
	word_t remainder_q;
	word_t denominator_q;
	logic negate_quotient;
	logic negate_remainder;
	logic [32:0] partial;

	assign numerator_abs = (i_signed && i_numerator[31]) ? -i_numerator : i_numerator;
	assign denominator_abs = (i_signed && i_denominator[31]) ? -i_denominator : i_denominator;

	// remainder shifted left with the next numerator bit
	assign partial = {remainder_q, quotient_q[31]};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running <= 1'b0;
			count <= '0;
		end else if (i_start) begin
			running <= 1'b1;
			count <= count_t'(DIV_STEPS);
		end else if (running && count != '0) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			quotient_q <= numerator_abs;
			remainder_q <= '0;
			denominator_q <= denominator_abs;
			// x/0 keeps an all-ones quotient, so no sign fix there
			negate_quotient <= i_signed && (i_numerator[31] ^ i_denominator[31]) &&
				(i_denominator != '0);
			negate_remainder <= i_signed && i_numerator[31];
		end else if (running && count != '0) begin
			if (partial >= {1'b0, denominator_q}) begin
				remainder_q <= word_t'(partial - {1'b0, denominator_q});
				quotient_q <= {quotient_q[30:0], 1'b1};
			end else begin
				remainder_q <= partial[31:0];
				quotient_q <= {quotient_q[30:0], 1'b0};
			end
		end
	end

	// sign fix-up; most negative / -1 wraps back to the numerator
	assign o_quotient = negate_quotient ? -quotient_q : quotient_q;
	assign o_remainder = negate_remainder ? -remainder_q : remainder_q;

	// held until the next start
	assign o_done = running && count == '0;

endmodule

`default_nettype wire

/* rtl/cpu_csr_file.sv */
`default_nettype none

module cpu_csr_file (
	input logic i_clock,
	input logic i_reset,
	cpu_csr_if.csr csr
);
	import cpu_types_pkg::*;
	import cpu_csr_pkg::*;

	word_t mscratch;
	word_t mtvec;
	word_t mepc;
	word_t mcause;

	// unknown addresses read as zero
	always_comb begin
		case (csr.index)
			CSR_MSCRATCH: csr.rdata = mscratch;
			CSR_MTVEC: csr.rdata = mtvec;
			CSR_MEPC: csr.rdata = mepc;
			CSR_MCAUSE: csr.rdata = mcause;
			default: csr.rdata = '0;
		endcase
	end

	assign csr.epc = mepc;
	assign csr.tvec = mtvec;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mscratch <= '0;
			mtvec <= MTVEC_RESET;
			mepc <= '0;
			mcause <= '0;
		end else begin
			if (csr.wdata_wr) begin
				case (csr.index)
					CSR_MSCRATCH: mscratch <= csr.wdata;
					CSR_MTVEC: mtvec <= csr.wdata;
					CSR_MEPC: mepc <= csr.wdata;
					CSR_MCAUSE: mcause <= csr.wdata;
					default: ;
				endcase
			end
			// trap capture wins over a plain write
			if (csr.ecall) begin
				mepc <= csr.ecall_pc;
				mcause <= CAUSE_ECALL;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/cpu_execute.sv */
`default_nettype none

module cpu_execute (
	input logic i_clock,
	input logic i_reset,
	input cpu_types_pkg::decode_data_t i_data,
	input cpu_types_pkg::word_t i_rs1,
	input cpu_types_pkg::word_t i_rs2,
	input logic i_memory_busy,
	output logic o_busy,
	output logic o_fault,
	output logic o_jump,
	output cpu_types_pkg::word_t o_jump_pc,
	output cpu_types_pkg::execute_data_t o_data,
	cpu_csr_if.execute csr
);
	import cpu_types_pkg::*;

	typedef logic [$clog2(MUL_LATENCY + 1) - 1:0] cycle_t;

	function automatic word_t select_operand(
		input operand_sel_t sel,
		input word_t rs1,
		input word_t rs2,
		input word_t pc,
		input word_t imm
	);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	cycle_t cycle;
	word_t alu_operand1;
	word_t alu_operand2;
	word_t alu_result;
	word_t alu_shift_result;
	word_t alu_signed_sum_result;
	logic alu_compare_result;
	logic mul_signed;
	logic [63:0] mul_result;
	logic div_start;
	logic div_signed;
	logic div_done;
	word_t div_quotient;
	word_t div_remainder;
	logic new_tag;
	logic advance;
	logic is_mul;
	logic is_div;
	logic is_csr;
	logic op_finish;
	logic [11:0] csr_write_index;
	word_t rd_next;
	word_t jump_target;
	word_t csr_wdata_next;
	logic jump_take;
	logic csr_write;
	logic ecall_take;
	logic bad_op;

	// ==================================================
	// functional units

	assign alu_operand1 = select_operand(i_data.operand1, i_rs1, i_rs2, i_data.pc, i_data.imm);
	assign alu_operand2 = select_operand(i_data.operand2, i_rs1, i_rs2, i_data.pc, i_data.imm);

	cpu_alu u_alu (
		.i_op(i_data.op),
		.i_op1(alu_operand1),
		.i_op2(alu_operand2),
		.o_result(alu_result),
		.o_shift_result(alu_shift_result),
		.o_signed_sum_result(alu_signed_sum_result),
		.o_compare_result(alu_compare_result)
	);

	assign mul_signed = i_data.op inside {OP_MUL, OP_MULH};

	cpu_multiply u_multiply (
		.i_clock(i_clock),
		.i_latch(cycle == '0),
		.i_op1_signed(mul_signed),
		.i_op2_signed(mul_signed),
		.i_op1(i_rs1),
		.i_op2(i_rs2),
		.o_result(mul_result)
	);

	assign div_signed = i_data.op inside {OP_DIV, OP_REM};
	assign div_start = advance && is_div && cycle == '0;

	cpu_divide u_divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(div_start),
		.i_signed(div_signed),
		.i_numerator(i_rs1),
		.i_denominator(i_rs2),
		.o_quotient(div_quotient),
		.o_remainder(div_remainder),
		.o_done(div_done)
	);

	// ==================================================
	// acceptance

	assign new_tag = i_data.tag != o_data.tag;
	assign advance = new_tag && !i_memory_busy;
	assign is_mul = i_data.op inside {OP_MUL, OP_MULH, OP_MULHU};
	assign is_div = i_data.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
	assign is_csr = i_data.op inside {OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET};

	// a stale divider done is ignored in the first cycle
	// CSR ops wait one cycle behind a pending CSR write or trap
	always_comb begin
		if (is_mul)
			op_finish = cycle == cycle_t'(MUL_LATENCY);
		else if (is_div)
			op_finish = div_done && cycle != '0;
		else
			op_finish = !(is_csr && (csr.wdata_wr || csr.ecall));
	end

	assign o_busy = i_memory_busy || (new_tag && (is_mul || is_div) && !op_finish);

	// write index held while the write pulse is out
	assign csr.index = csr.wdata_wr ? csr_write_index : i_data.imm[11:0];

	always_comb begin
		rd_next = '0;
		jump_take = 1'b0;
		jump_target = i_data.pc + 32'd4;
		csr_write = 1'b0;
		csr_wdata_next = i_rs1;
		ecall_take = 1'b0;
		bad_op = 1'b0;
		case (i_data.op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: rd_next = alu_result;
			OP_SLL, OP_SRL, OP_SRA: rd_next = alu_shift_result;
			OP_SLT, OP_SLTU: rd_next = {31'b0, alu_compare_result};
			OP_JAL: begin
				rd_next = i_data.pc + 32'd4;
				jump_take = 1'b1;
				jump_target = alu_signed_sum_result;
			end
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
				jump_take = 1'b1;
				if (alu_compare_result)
					jump_target = i_data.pc + i_data.imm;
			end
			OP_LOAD: ;
			OP_STORE: rd_next = i_rs2;
			OP_MUL: rd_next = mul_result[31:0];
			OP_MULH, OP_MULHU: rd_next = mul_result[63:32];
			OP_DIV, OP_DIVU: rd_next = div_quotient;
			OP_REM, OP_REMU: rd_next = div_remainder;
			OP_CSRRW, OP_CSRRS: begin
				rd_next = csr.rdata;
				csr_write = 1'b1;
				if (i_data.op == OP_CSRRS)
					csr_wdata_next = csr.rdata | i_rs1;
			end
			OP_ECALL: begin
				ecall_take = 1'b1;
				jump_take = 1'b1;
				jump_target = csr.tvec;
			end
			OP_MRET: begin
				jump_take = 1'b1;
				jump_target = csr.epc;
			end
			default: bad_op = 1'b1;
		endcase
	end

	// ==================================================
	// state and output record

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle <= '0;
			o_data <= '0;
			o_jump <= 1'b0;
			o_fault <= 1'b0;
			csr.wdata_wr <= 1'b0;
			csr.ecall <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			csr.wdata_wr <= 1'b0;
			csr.ecall <= 1'b0;
			if (advance && op_finish) begin
				cycle <= '0;
				o_jump <= jump_take;
				csr.wdata_wr <= csr_write;
				csr.ecall <= ecall_take;
				if (bad_op)
					o_fault <= 1'b1;
				o_data.tag <= i_data.tag;
				o_data.rd <= rd_next;
				o_data.inst_rd <= (i_data.op == OP_LOAD) ? register_t'(0) : i_data.inst_rd;
				o_data.mem_read <= i_data.op == OP_LOAD;
				o_data.mem_write <= i_data.op == OP_STORE;
				o_data.mem_width <= i_data.mem_width;
				o_data.mem_signed <= i_data.mem_signed;
				o_data.mem_address <= alu_signed_sum_result;
				o_data.mem_inst_rd <= i_data.inst_rd;
			end else if (advance && cycle != cycle_t'(MUL_LATENCY)) begin
				cycle <= cycle + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (advance && op_finish) begin
			o_jump_pc <= jump_target;
			csr.wdata <= csr_wdata_next;
			csr.ecall_pc <= i_data.pc;
			csr_write_index <= i_data.imm[11:0];
		end
	end

endmodule

`default_nettype wire

/* rtl/cpu_execute_top.sv */
`default_nettype none

module cpu_execute_top (
	input logic i_clock,
	input logic i_reset,
	input cpu_types_pkg::tag_t i_tag,
	input logic [4:0] i_op,
	input cpu_types_pkg::operand_sel_t i_operand1_sel,
	input cpu_types_pkg::operand_sel_t i_operand2_sel,
	input cpu_types_pkg::word_t i_pc,
	input cpu_types_pkg::word_t i_imm,
	input cpu_types_pkg::word_t i_rs1,
	input cpu_types_pkg::word_t i_rs2,
	input cpu_types_pkg::register_t i_inst_rd,
	input cpu_types_pkg::mem_width_t i_mem_width,
	input logic i_mem_signed,
	input logic i_memory_busy,
	output logic o_busy,
	output logic o_fault,
	output logic o_jump,
	output cpu_types_pkg::word_t o_jump_pc,
	output logic o_ecall,
	output cpu_types_pkg::tag_t o_tag,
	output cpu_types_pkg::word_t o_rd,
	output cpu_types_pkg::register_t o_inst_rd,
	output logic o_mem_read,
	output logic o_mem_write,
	output cpu_types_pkg::word_t o_mem_address
);
	import cpu_types_pkg::*;

	decode_data_t decode;
	execute_data_t result;

	cpu_csr_if csr_bus ();

	// ==================================================
	// decode record

	always_comb begin
		decode.tag = i_tag;
		decode.pc = i_pc;
		decode.imm = i_imm;
		decode.op = exec_op_t'(i_op);
		decode.operand1 = i_operand1_sel;
		decode.operand2 = i_operand2_sel;
		decode.inst_rd = i_inst_rd;
		decode.mem_width = i_mem_width;
		decode.mem_signed = i_mem_signed;
	end

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(decode),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_memory_busy(i_memory_busy),
		.o_busy(o_busy),
		.o_fault(o_fault),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_data(result),
		.csr(csr_bus.execute)
	);

	cpu_csr_file u_csr_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.csr(csr_bus.csr)
	);

	// ==================================================
	// result record

	assign o_ecall = csr_bus.ecall;
	assign o_tag = result.tag;
	assign o_rd = result.rd;
	assign o_inst_rd = result.inst_rd;
	assign o_mem_read = result.mem_read;
	assign o_mem_write = result.mem_write;
	assign o_mem_address = result.mem_address;

endmodule

`default_nettype wire

/* verification/cpu_execute_assertions.sv */
`default_nettype none

module cpu_execute_assertions (
	input logic i_clock,
	input logic i_reset,
	input logic i_memory_busy,
	input logic i_busy,
	input logic i_jump,
	input logic i_fault,
	input cpu_types_pkg::tag_t i_tag
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int failure_count = 0;

	// redirect is a single-cycle pulse
	jump_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_jump |=> !i_jump)
		else begin
			$error("o_jump stayed high for two cycles");
			failure_count++;
		end

	// ==================================================
	// back-pressure from the memory stage

	busy_follows_memory: assert property (@(posedge i_clock) disable iff (i_reset)
		i_memory_busy |-> i_busy)
		else begin
			$error("o_busy low while memory stage busy");
			failure_count++;
		end

	tag_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_memory_busy |=> $stable(i_tag))
		else begin
			$error("result tag changed while memory stage busy");
			failure_count++;
		end

	fault_clear: assert property (@(posedge i_clock) $fell(i_reset) |-> !i_fault)
		else begin
			$error("o_fault set right after reset");
			failure_count++;
		end

endmodule

bind cpu_execute cpu_execute_assertions u_assertions (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_memory_busy(i_memory_busy),
	.i_busy(o_busy),
	.i_jump(o_jump),
	.i_fault(o_fault),
	.i_tag(o_data.tag)
);

`default_nettype wire

/* verification/tb_cpu_execute.sv */
`default_nettype none

module tb_cpu_execute;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_types_pkg::*;
	import cpu_csr_pkg::*;

	typedef struct packed {
		logic [4:0] op;
		operand_sel_t sel1;
		operand_sel_t sel2;
		word_t pc;
		word_t imm;
		word_t rs1;
		word_t rs2;
		register_t inst_rd;
		logic [3:0] stall;
		word_t exp_rd;
		logic exp_jump;
		word_t exp_jump_pc;
		logic exp_fault;
	} entry_t;

	logic i_clock;
	logic i_reset;
	tag_t i_tag;
	logic [4:0] i_op;
	operand_sel_t i_operand1_sel;
	operand_sel_t i_operand2_sel;
	word_t i_pc;
	word_t i_imm;
	word_t i_rs1;
	word_t i_rs2;
	register_t i_inst_rd;
	mem_width_t i_mem_width;
	logic i_mem_signed;
	logic i_memory_busy;
	logic o_busy;
	logic o_fault;
	logic o_jump;
	word_t o_jump_pc;
	logic o_ecall;
	tag_t o_tag;
	word_t o_rd;
	register_t o_inst_rd;
	logic o_mem_read;
	logic o_mem_write;
	word_t o_mem_address;

	entry_t entries[$];
	string names[$];
	integer seed;
	logic fault_expected;
	int cycle_count = 0;
	int timeout_limit = 0;

	cpu_execute_top DUT (.*);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (timeout_limit > 0 && cycle_count > timeout_limit)
			abort_run($sformatf("timeout: no result after %0d cycles", cycle_count));
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// ==================================================
	// compare tasks

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_reg(input string name, input register_t expected,
		input register_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("Fail %s expected %b actual %b", name, expected, actual));
	endtask

	// ==================================================
	// reference model from the RV32IM rules

	function automatic word_t ref_result(input exec_op_t op, input word_t a, input word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] product;
		sa = $signed(a);
		sb = $signed(b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << b[4:0];
			OP_SRL: return a >> b[4:0];
			OP_SRA: return word_t'(sa >>> b[4:0]);
			OP_SLT: return word_t'(sa < sb);
			OP_SLTU: return word_t'(a < b);
			OP_MUL, OP_MULH: begin
				product = sa * sb;
				return (op == OP_MUL) ? product[31:0] : product[63:32];
			end
			OP_MULHU: begin
				product = {32'b0, a} * {32'b0, b};
				return product[63:32];
			end
			// 64-bit math already wraps the signed overflow case
			OP_DIV: return (b == '0) ? '1 : word_t'(sa / sb);
			OP_REM: return (b == '0) ? a : word_t'(sa % sb);
			OP_DIVU: return (b == '0) ? '1 : a / b;
			OP_REMU: return (b == '0) ? a : a % b;
			default: return '0;
		endcase
	endfunction

	task automatic add_entry(input string name, input logic [4:0] op,
		input operand_sel_t sel1, input operand_sel_t sel2,
		input word_t pc, input word_t imm, input word_t rs1, input word_t rs2,
		input logic [3:0] stall, input word_t exp_rd,
		input logic exp_jump, input word_t exp_jump_pc);
		entry_t e;
		e.op = op;
		e.sel1 = sel1;
		e.sel2 = sel2;
		e.pc = pc;
		e.imm = imm;
		e.rs1 = rs1;
		e.rs2 = rs2;
		e.inst_rd = register_t'(entries.size() % 31 + 1);
		e.stall = stall;
		e.exp_rd = exp_rd;
		e.exp_jump = exp_jump;
		e.exp_jump_pc = exp_jump_pc;
		e.exp_fault = op >= 5'd28;
		entries.push_back(e);
		names.push_back(name);
	endtask

	task automatic add_arith(input string name, input exec_op_t op, input word_t a,
		input word_t b);
		add_entry(name, op, SEL_RS1, SEL_RS2, '0, '0, a, b, 4'd0, ref_result(op, a, b),
			1'b0, '0);
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		exec_op_t op;
		int k;
		for (k = int'(OP_ADD); k <= int'(OP_SLTU); k++) begin
			op = exec_op_t'(k);
			a = $random(seed);
			b = $random(seed);
			add_arith({"random ", op.name()}, op, a, b);
		end
		for (k = int'(OP_MUL); k <= int'(OP_REMU); k++) begin
			op = exec_op_t'(k);
			a = $random(seed);
			b = $random(seed);
			add_arith({"random ", op.name()}, op, a, b);
		end
		add_arith("div by zero", OP_DIV, 32'hffff_fff9, 32'h0);
		add_arith("remu by zero", OP_REMU, 32'h1234_5678, 32'h0);
		add_arith("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		add_arith("rem overflow", OP_REM, 32'h8000_0000, 32'hffff_ffff);
		add_arith("rem negative", OP_REM, 32'hffff_fff9, 32'd2);
		add_entry("addi", OP_ADD, SEL_RS1, SEL_IMM, '0, 32'hffff_fff0, 32'h100, '0,
			4'd0, 32'h0000_00f0, 1'b0, '0);
		add_entry("mul stalled", OP_MUL, SEL_RS1, SEL_RS2, '0, '0, 32'h0001_0003,
			32'h0002_0005, 4'd3, ref_result(OP_MUL, 32'h0001_0003, 32'h0002_0005), 1'b0, '0);
		// untaken branches still redirect to pc+4
		add_entry("jal", OP_JAL, SEL_RS1, SEL_IMM, 32'h1000, 32'h24, 32'h2000, '0,
			4'd0, 32'h1004, 1'b1, 32'h2024);
		add_entry("beq taken", OP_BEQ, SEL_RS1, SEL_RS2, 32'h3000, 32'h40, 32'd5, 32'd5,
			4'd0, '0, 1'b1, 32'h3040);
		add_entry("bne not taken", OP_BNE, SEL_RS1, SEL_RS2, 32'h3000, 32'h40, 32'd5, 32'd5,
			4'd0, '0, 1'b1, 32'h3004);
		add_entry("blt taken", OP_BLT, SEL_RS1, SEL_RS2, 32'h3100, 32'hffff_ffc0,
			32'hffff_fffd, 32'd2, 4'd0, '0, 1'b1, 32'h30c0);
		add_entry("bge not taken", OP_BGE, SEL_RS1, SEL_RS2, 32'h3200, 32'h80,
			32'hffff_fffd, 32'd2, 4'd0, '0, 1'b1, 32'h3204);
		add_entry("load stalled", OP_LOAD, SEL_RS1, SEL_IMM, 32'h500, 32'h10, 32'h8000,
			32'h77, 4'd4, '0, 1'b0, '0);
		add_entry("store stalled", OP_STORE, SEL_RS1, SEL_IMM, 32'h504, 32'h8, 32'h9000,
			32'hcafe_f00d, 4'd3, 32'hcafe_f00d, 1'b0, '0);
		// machine CSRs and traps
		add_entry("csrrw mscratch", OP_CSRRW, SEL_RS1, SEL_IMM, 32'h600,
			word_t'(CSR_MSCRATCH), 32'h1234_5678, '0, 4'd0, '0, 1'b0, '0);
		add_entry("csrrs mscratch", OP_CSRRS, SEL_RS1, SEL_IMM, 32'h604,
			word_t'(CSR_MSCRATCH), 32'h0000_00f0, '0, 4'd0, 32'h1234_5678, 1'b0, '0);
		add_entry("ecall", OP_ECALL, SEL_RS1, SEL_IMM, 32'h4444, '0, '0, '0,
			4'd0, '0, 1'b1, MTVEC_RESET);
		add_entry("csrrs mcause", OP_CSRRS, SEL_RS1, SEL_IMM, 32'h104,
			word_t'(CSR_MCAUSE), '0, '0, 4'd0, CAUSE_ECALL, 1'b0, '0);
		add_entry("csrrs mepc", OP_CSRRS, SEL_RS1, SEL_IMM, 32'h108,
			word_t'(CSR_MEPC), '0, '0, 4'd0, 32'h4444, 1'b0, '0);
		add_entry("mret", OP_MRET, SEL_RS1, SEL_IMM, 32'h10c, '0, '0, '0,
			4'd0, '0, 1'b1, 32'h4444);
		add_entry("undefined op", 5'd30, SEL_RS1, SEL_RS2, 32'h4448, '0, 32'd1, 32'd2,
			4'd0, '0, 1'b0, '0);
		add_entry("add after fault", OP_ADD, SEL_RS1, SEL_RS2, 32'h444c, '0, 32'd3, 32'd4,
			4'd0, 32'd7, 1'b0, '0);
	endtask

	// ==================================================
	// apply one entry and check its result

	task automatic run_entry(input int index);
		entry_t e;
		string name;
		tag_t prev_tag;
		tag_t tag;
		logic multi;
		logic busy_low;
		e = entries[index];
		name = names[index];
		prev_tag = o_tag;
		tag = prev_tag + 1'b1;
		multi = e.op inside {[OP_MUL:OP_REMU]};
		i_tag = tag;
		i_op = e.op;
		i_operand1_sel = e.sel1;
		i_operand2_sel = e.sel2;
		i_pc = e.pc;
		i_imm = e.imm;
		i_rs1 = e.rs1;
		i_rs2 = e.rs2;
		i_inst_rd = e.inst_rd;
		i_memory_busy = e.stall != 0;
		#1;
		if (e.stall == 0)
			check_flag({name, " busy"}, multi, o_busy);
		repeat (e.stall) begin
			@(posedge i_clock);
			#1;
			check_tag({name, " tag held"}, prev_tag, o_tag);
			check_flag({name, " busy while stalled"}, 1'b1, o_busy);
		end
		i_memory_busy = 1'b0;
		busy_low = 1'b0;
		@(posedge i_clock);
		#1;
		while (o_tag !== tag) begin
			// busy may only drop in the cycle that completes the operation
			if (multi && busy_low)
				abort_run({name, ": o_busy dropped before the result was ready"});
			busy_low = !o_busy;
			// operands may change once the unit has captured them
			if (multi) begin
				i_rs1 = $random(seed);
				i_rs2 = $random(seed);
			end
			@(posedge i_clock);
			#1;
		end
		if (multi)
			check_flag({name, " busy released in last cycle"}, 1'b1, busy_low);
		check_flag({name, " busy after result"}, 1'b0, o_busy);
		fault_expected = fault_expected | e.exp_fault;
		check_word({name, " rd"}, e.exp_rd, o_rd);
		check_reg({name, " inst_rd"}, (e.op == OP_LOAD) ? register_t'(0) : e.inst_rd,
			o_inst_rd);
		check_flag({name, " jump"}, e.exp_jump, o_jump);
		if (e.exp_jump)
			check_word({name, " jump pc"}, e.exp_jump_pc, o_jump_pc);
		check_flag({name, " ecall"}, e.op == OP_ECALL, o_ecall);
		check_flag({name, " fault"}, fault_expected, o_fault);
		check_flag({name, " mem read"}, e.op == OP_LOAD, o_mem_read);
		check_flag({name, " mem write"}, e.op == OP_STORE, o_mem_write);
		if (e.op == OP_LOAD || e.op == OP_STORE)
			check_word({name, " address"}, e.rs1 + e.imm, o_mem_address);
		// pulses must be gone after one idle cycle
		@(posedge i_clock);
		#1;
		check_flag({name, " jump pulse end"}, 1'b0, o_jump);
		check_flag({name, " ecall pulse end"}, 1'b0, o_ecall);
	endtask

	initial begin
		seed = 32'h2b93b501;
		fault_expected = 1'b0;
		i_reset = 1'b1;
		i_tag = '0;
		i_op = '0;
		i_operand1_sel = SEL_ZERO;
		i_operand2_sel = SEL_ZERO;
		i_pc = '0;
		i_imm = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_inst_rd = '0;
		i_mem_width = WIDTH_WORD;
		i_mem_signed = 1'b0;
		i_memory_busy = 1'b0;
		build_table();
		timeout_limit = 16 + entries.size() * (DIV_STEPS + 8);
		repeat (16) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		for (int i = 0; i < entries.size(); i++)
			run_entry(i);
		if (DUT.u_execute.u_assertions.failure_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run("concurrent assertions on the execute stage failed");
		end
	end

endmodule

`default_nettype wire

/* src.f */
rtl/cpu_types_pkg.sv
rtl/cpu_csr_pkg.sv
rtl/cpu_csr_if.sv
rtl/cpu_alu.sv
rtl/cpu_multiply.sv
rtl/cpu_divide.sv
rtl/cpu_csr_file.sv
rtl/cpu_execute.sv
rtl/cpu_execute_top.sv
verification/cpu_execute_assertions.sv
verification/tb_cpu_execute.sv
